// File: rtl/uart_pkg.sv
package uart_pkg;

    localparam int CLK_FREQ     = 50_000_000;   // system clock in hz
    localparam int BAUD_RATE    = 115_200;      // host link speed
    localparam int RX_TICK_BAUD = 16;           // samples per bit

    // clocks per sample tick, 27 at the rates above
    localparam int TICK_DIV     = CLK_FREQ / (BAUD_RATE * RX_TICK_BAUD);

    localparam int TICK_CNT_W   = $clog2(TICK_DIV);        // divider counter width
    localparam int SAMPLE_CNT_W = $clog2(RX_TICK_BAUD);    // sample counter width

    typedef logic [7:0] byte_t;                 // one received frame

endpackage

// File: rtl/debug_pkg.sv
package debug_pkg;

    localparam int MEM_DEPTH = 256;             // instruction memory words

    typedef logic [31:0] word_t;                // instruction word
    typedef logic [$clog2(MEM_DEPTH)-1:0] addr_t;   // memory address and pc
    typedef logic [31:0] count_t;               // executed fetch cycles

    localparam word_t HALT_WORD = '1;           // all ones stops a run

    // command bytes sent by the host, plain ascii letters
    localparam uart_pkg::byte_t CMD_LOAD  = 8'h4C;  // 'L'
    localparam uart_pkg::byte_t CMD_STEP  = 8'h53;  // 'S'
    localparam uart_pkg::byte_t CMD_RUN   = 8'h52;  // 'R'
    localparam uart_pkg::byte_t CMD_CLEAR = 8'h5A;  // 'Z'

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,   // waiting for a command byte
        ST_LOAD_COUNT = 4'd1,   // next byte is the word count
        ST_LOAD_BYTE  = 4'd2,   // collecting the four bytes of a word
        ST_LOAD_WRITE = 4'd3,   // one cycle write strobe
        ST_STEP       = 4'd4,   // single fetch
        ST_RUN        = 4'd5    // fetch every cycle until halt
    } debug_state_t;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/10ps

module uart_rx (
    input  logic            wire_clk_wz,
    input  logic            i_reset,
    input  logic            i_uart_rx,
    output uart_pkg::byte_t o_rx_data,
    output logic            o_rx_done
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t                          state;
    logic                               rx_meta;
    logic                               rx_sync;
    logic [uart_pkg::TICK_CNT_W-1:0]    tick_cnt;
    logic                               tick;
    logic [uart_pkg::SAMPLE_CNT_W-1:0]  samp_cnt;
    logic [2:0]                         bit_cnt;
    uart_pkg::byte_t                    shift_reg;
    logic                               bit_mid;
    logic                               frame_ok;

    // two flops against metastability, line idles high
    always_ff @(posedge wire_clk_wz) begin
        if (i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_uart_rx;
            rx_sync <= rx_meta;
        end
    end

    // free running sample tick divider
    always_ff @(posedge wire_clk_wz) begin
        if (i_reset || tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign tick     = (tick_cnt == uart_pkg::TICK_CNT_W'(uart_pkg::TICK_DIV - 1));
    assign bit_mid  = tick && (samp_cnt == uart_pkg::SAMPLE_CNT_W'(uart_pkg::RX_TICK_BAUD - 1));
    assign frame_ok = (state == RX_STOP) && bit_mid && rx_sync;   // stop bit must be high

    always_ff @(posedge wire_clk_wz) begin
        if (i_reset) begin
            state     <= RX_IDLE;
            samp_cnt  <= '0;
            bit_cnt   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            o_rx_done <= frame_ok;
            case (state)
                RX_IDLE: begin
                    samp_cnt <= '0;
                    if (!rx_sync)
                        state <= RX_START;              // falling start edge
                end
                RX_START: begin
                    if (tick) begin
                        if (samp_cnt == uart_pkg::SAMPLE_CNT_W'(uart_pkg::RX_TICK_BAUD / 2 - 1)) begin
                            samp_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_sync ? RX_IDLE : RX_DATA;    // reject glitches
                        end else begin
                            samp_cnt <= samp_cnt + 1'b1;
                        end
                    end
                end
                RX_DATA: begin
                    if (tick)
                        samp_cnt <= samp_cnt + 1'b1;    // wraps at the bit boundary
                    if (bit_mid && bit_cnt == 3'd7)
                        state <= RX_STOP;
                    else if (bit_mid)
                        bit_cnt <= bit_cnt + 1'b1;
                end
                RX_STOP: begin
                    if (tick)
                        samp_cnt <= samp_cnt + 1'b1;
                    if (bit_mid)
                        state <= RX_IDLE;               // low stop bit just drops the byte
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // data path, lsb arrives first
    always_ff @(posedge wire_clk_wz) begin
        if (state == RX_DATA && bit_mid)
            shift_reg <= {rx_sync, shift_reg[7:1]};
        if (frame_ok)
            o_rx_data <= shift_reg;                     // held until the next good frame
    end

endmodule

// File: rtl/debug_unit.sv
`timescale 1ns/10ps

module debug_unit (
    input  logic              wire_clk_wz,
    input  logic              i_reset,
    input  uart_pkg::byte_t   i_rx_data,
    input  logic              i_rx_done,
    input  logic              i_halt,
    output logic              o_mem_wr_en,
    output debug_pkg::addr_t  o_mem_wr_addr,
    output debug_pkg::word_t  o_mem_wr_data,
    output logic              o_step_en,
    output logic              o_pc_clear,
    output logic [3:0]        o_debug_state
);

    debug_pkg::debug_state_t state;
    debug_pkg::addr_t        words_left;    // words still to load
    logic [1:0]              lane;          // byte position inside the word
    debug_pkg::word_t        word_sr;       // word being assembled
    debug_pkg::addr_t        wr_addr;
    logic                    cmd_valid;

    assign cmd_valid = i_rx_done && (state == debug_pkg::ST_IDLE);

    always_ff @(posedge wire_clk_wz) begin
        if (i_reset) begin
            state      <= debug_pkg::ST_IDLE;
            words_left <= '0;
            lane       <= '0;
            wr_addr    <= '0;
            o_pc_clear <= 1'b0;
        end else begin
            o_pc_clear <= cmd_valid && (i_rx_data == debug_pkg::CMD_CLEAR);
            case (state)
                debug_pkg::ST_IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            debug_pkg::CMD_LOAD:  state <= debug_pkg::ST_LOAD_COUNT;
                            debug_pkg::CMD_STEP:  state <= debug_pkg::ST_STEP;
                            debug_pkg::CMD_RUN:   state <= debug_pkg::ST_RUN;
                            default:              state <= debug_pkg::ST_IDLE;  // clear or unknown
                        endcase
                    end
                end
                debug_pkg::ST_LOAD_COUNT: begin
                    if (i_rx_done) begin
                        words_left <= i_rx_data;
                        lane       <= '0;
                        wr_addr    <= '0;       // every load starts at address 0
                        if (i_rx_data == '0)
                            state <= debug_pkg::ST_IDLE;
                        else
                            state <= debug_pkg::ST_LOAD_BYTE;
                    end
                end
                debug_pkg::ST_LOAD_BYTE: begin
                    if (i_rx_done) begin
                        lane <= lane + 1'b1;
                        if (lane == 2'd3)
                            state <= debug_pkg::ST_LOAD_WRITE;  // fourth byte is in
                    end
                end
                debug_pkg::ST_LOAD_WRITE: begin
                    wr_addr    <= wr_addr + 1'b1;
                    words_left <= words_left - 1'b1;
                    if (words_left == debug_pkg::addr_t'(1))
                        state <= debug_pkg::ST_IDLE;
                    else
                        state <= debug_pkg::ST_LOAD_BYTE;
                end
                debug_pkg::ST_STEP: begin
                    state <= debug_pkg::ST_IDLE;        // one fetch only
                end
                debug_pkg::ST_RUN: begin
                    // received bytes are ignored here, only halt ends the run
                    if (i_halt)
                        state <= debug_pkg::ST_IDLE;
                end
                default: state <= debug_pkg::ST_IDLE;
            endcase
        end
    end

    // first byte ends up in the low lane after four shifts
    always_ff @(posedge wire_clk_wz) begin
        if (state == debug_pkg::ST_LOAD_BYTE && i_rx_done)
            word_sr <= {i_rx_data, word_sr[31:8]};
    end

    assign o_mem_wr_en   = (state == debug_pkg::ST_LOAD_WRITE);
    assign o_mem_wr_addr = wr_addr;
    assign o_mem_wr_data = word_sr;

    // no fetch while the halt word sits in the instruction register
    assign o_step_en = ((state == debug_pkg::ST_STEP) || (state == debug_pkg::ST_RUN)) && !i_halt;

    assign o_debug_state = 4'(state);

endmodule

// File: rtl/instr_mem.sv
`timescale 1ns/10ps

module instr_mem (
    input  logic              wire_clk_wz,
    input  logic              i_wr_en,
    input  debug_pkg::addr_t  i_wr_addr,
    input  debug_pkg::word_t  i_wr_data,
    input  debug_pkg::addr_t  i_rd_addr,
    output debug_pkg::word_t  o_rd_data
);

    debug_pkg::word_t mem [debug_pkg::MEM_DEPTH];

    // write from the debug unit
    always_ff @(posedge wire_clk_wz) begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_data;
    end

    // registered read, same address collision returns the old word
    always_ff @(posedge wire_clk_wz) begin
        o_rd_data <= mem[i_rd_addr];
    end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/10ps

module fetch_unit (
    input  logic               wire_clk_wz,
    input  logic               i_reset,
    input  logic               i_step_en,
    input  logic               i_pc_clear,
    input  debug_pkg::word_t   i_rd_data,
    output debug_pkg::addr_t   o_rd_addr,
    output debug_pkg::addr_t   o_pc,
    output debug_pkg::word_t   o_instr,
    output debug_pkg::count_t  o_cycle_count,
    output logic               o_halt
);

    debug_pkg::addr_t pc_next;

    assign pc_next = o_pc + 1'b1;       // wraps at the top of memory

    // look ahead so the read data matches the pc at the next edge
    always_comb begin
        if (i_pc_clear)
            o_rd_addr = '0;
        else if (i_step_en)
            o_rd_addr = pc_next;
        else
            o_rd_addr = o_pc;
    end

    always_ff @(posedge wire_clk_wz) begin
        if (i_reset || i_pc_clear) begin
            o_pc          <= '0;
            o_instr       <= '0;
            o_cycle_count <= '0;
        end else if (i_step_en) begin
            o_pc          <= pc_next;
            o_instr       <= i_rd_data;   // word at the current pc
            o_cycle_count <= o_cycle_count + 1'b1;
        end
    end

    assign o_halt = (o_instr == debug_pkg::HALT_WORD);

endmodule

// File: rtl/debug_top.sv
`timescale 1ns/10ps

module debug_top (
    input  logic               wire_clk_wz,
    input  logic               i_reset,
    input  logic               i_uart_rx,
    output debug_pkg::addr_t   o_pc,
    output debug_pkg::word_t   o_instr,
    output debug_pkg::count_t  o_cycle_count,
    output logic               o_halt,
    output logic [3:0]         o_debug_state
);

    uart_pkg::byte_t   rx_data;
    logic              rx_done;
    logic              mem_wr_en;
    debug_pkg::addr_t  mem_wr_addr;
    debug_pkg::word_t  mem_wr_data;
    debug_pkg::addr_t  mem_rd_addr;
    debug_pkg::word_t  mem_rd_data;
    logic              step_en;
    logic              pc_clear;
    logic              halt;

    uart_rx u_uart_rx (
        .wire_clk_wz   (wire_clk_wz),
        .i_reset       (i_reset),
        .i_uart_rx     (i_uart_rx),
        .o_rx_data     (rx_data),
        .o_rx_done     (rx_done)
    );

    debug_unit u_debug_unit (
        .wire_clk_wz   (wire_clk_wz),
        .i_reset       (i_reset),
        .i_rx_data     (rx_data),
        .i_rx_done     (rx_done),
        .i_halt        (halt),
        .o_mem_wr_en   (mem_wr_en),
        .o_mem_wr_addr (mem_wr_addr),
        .o_mem_wr_data (mem_wr_data),
        .o_step_en     (step_en),
        .o_pc_clear    (pc_clear),
        .o_debug_state (o_debug_state)
    );

    instr_mem u_instr_mem (
        .wire_clk_wz   (wire_clk_wz),
        .i_wr_en       (mem_wr_en),
        .i_wr_addr     (mem_wr_addr),
        .i_wr_data     (mem_wr_data),
        .i_rd_addr     (mem_rd_addr),
        .o_rd_data     (mem_rd_data)
    );

    fetch_unit u_fetch_unit (
        .wire_clk_wz   (wire_clk_wz),
        .i_reset       (i_reset),
        .i_step_en     (step_en),
        .i_pc_clear    (pc_clear),
        .i_rd_data     (mem_rd_data),
        .o_rd_addr     (mem_rd_addr),
        .o_pc          (o_pc),
        .o_instr       (o_instr),
        .o_cycle_count (o_cycle_count),
        .o_halt        (halt)
    );

    assign o_halt = halt;   // also feeds the debug unit

endmodule

// File: dv/debug_checker.sv
`timescale 1ns/10ps

module debug_checker (
    input  logic               wire_clk_wz,
    input  logic               i_reset,
    input  logic               i_step_en,
    input  logic               i_pc_clear,
    input  debug_pkg::word_t   i_instr,
    input  logic               i_rx_done,
    input  logic               i_mem_wr_en,
    input  debug_pkg::addr_t   i_pc,
    input  debug_pkg::count_t  i_cycle_count,
    input  logic [3:0]         i_debug_state
);

    int unsigned failures = 0;      // polled from the testbench top

    step_advances: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        i_step_en && !i_pc_clear |=>
            (i_pc == debug_pkg::addr_t'($past(i_pc) + 1'b1)) &&
            (i_cycle_count == debug_pkg::count_t'($past(i_cycle_count) + 1'b1)))
    else begin
        $error("pc or cycle count did not advance after a step");
        failures++;
    end

    hold_without_step: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        !i_step_en && !i_pc_clear |=> $stable(i_pc) && $stable(i_cycle_count))
    else begin
        $error("pc or cycle count changed without a step or clear");
        failures++;
    end

    clear_zeroes: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        i_pc_clear |=> (i_pc == '0) && (i_cycle_count == '0))
    else begin
        $error("clear did not zero pc and cycle count");
        failures++;
    end

    // a halted core must not fetch again
    no_step_on_halt: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        !(i_step_en && (i_instr == debug_pkg::HALT_WORD)))
    else begin
        $error("step enable raised while halted");
        failures++;
    end

    // a word is written one cycle after its fourth byte
    write_in_load_state: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        i_mem_wr_en |-> (i_debug_state == 4'(debug_pkg::ST_LOAD_WRITE)) && $past(i_rx_done))
    else begin
        $error("memory write outside the load write state or not after a received byte");
        failures++;
    end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/10ps

module tb_top;

    localparam int BIT_CYCLES = uart_pkg::TICK_DIV * uart_pkg::RX_TICK_BAUD;
    localparam int WAIT_LIMIT = 2 * BIT_CYCLES;     // cycles allowed per wait

    logic              wire_clk_wz = 1'b0;
    logic              i_reset;
    logic              i_uart_rx;
    debug_pkg::addr_t  o_pc;
    debug_pkg::word_t  o_instr;
    debug_pkg::count_t o_cycle_count;
    logic              o_halt;
    logic [3:0]        o_debug_state;

    debug_pkg::word_t  model_mem [debug_pkg::MEM_DEPTH];   // what the memory should hold
    debug_pkg::addr_t  model_pc;
    debug_pkg::word_t  model_instr;
    debug_pkg::count_t model_count;
    int                seed;

    debug_top i_dut (
        .wire_clk_wz   (wire_clk_wz),
        .i_reset       (i_reset),
        .i_uart_rx     (i_uart_rx),
        .o_pc          (o_pc),
        .o_instr       (o_instr),
        .o_cycle_count (o_cycle_count),
        .o_halt        (o_halt),
        .o_debug_state (o_debug_state)
    );

    bind debug_top debug_checker u_checker (
        .wire_clk_wz   (wire_clk_wz),
        .i_reset       (i_reset),
        .i_step_en     (step_en),
        .i_pc_clear    (pc_clear),
        .i_instr       (o_instr),
        .i_rx_done     (rx_done),
        .i_mem_wr_en   (mem_wr_en),
        .i_pc          (o_pc),
        .i_cycle_count (o_cycle_count),
        .i_debug_state (o_debug_state)
    );

    always #10 wire_clk_wz = ~wire_clk_wz;     // 20 ns period

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected)
        else abort_run($sformatf("ERROR at %0t ns: %s is %0h, expected %0h",
                                 $time, what, actual, expected));
    endtask

    always @(negedge wire_clk_wz) begin
        if (i_dut.u_checker.failures != 0)
            abort_run("A concurrent assertion in the bound checker failed");
    end

    function automatic debug_pkg::word_t random_word();
        debug_pkg::word_t w;
        w = $random(seed);
        if (w == debug_pkg::HALT_WORD)
            w = 32'h0000_0013;                  // keep the halt word out of the body
        return w;
    endfunction

    // one fetch as the fetch unit should perform it
    function automatic void model_step();
        if (model_instr !== debug_pkg::HALT_WORD) begin
            model_instr = model_mem[model_pc];
            model_pc    = model_pc + 1'b1;
            model_count = model_count + 1;
        end
    endfunction

    task automatic drive_line(input logic level, input int cycles);
        @(posedge wire_clk_wz);
        i_uart_rx <= level;
        repeat (cycles - 1) @(posedge wire_clk_wz);
    endtask

    task automatic send_frame(input uart_pkg::byte_t data, input logic stop_bit);
        int i;
        drive_line(1'b0, BIT_CYCLES);               // start bit
        for (i = 0; i < 8; i++)
            drive_line(data[i], BIT_CYCLES);        // lsb first
        if (stop_bit) begin
            drive_line(1'b1, BIT_CYCLES);
        end else begin
            drive_line(1'b0, BIT_CYCLES * 3 / 4);   // low through the stop sample point
            drive_line(1'b1, BIT_CYCLES * 5 / 4);
        end
    endtask

    task automatic send_byte(input uart_pkg::byte_t data);
        send_frame(data, 1'b1);
    endtask

    task automatic wait_pc(input debug_pkg::addr_t expected);
        int cycles;
        cycles = 0;
        @(negedge wire_clk_wz);
        while (o_pc !== expected && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge wire_clk_wz);
        end
        if (o_pc !== expected)
            abort_run("Timeout while waiting for the PC to reach its expected value");
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge wire_clk_wz);
        while (o_debug_state !== 4'(debug_pkg::ST_IDLE) && cycles < WAIT_LIMIT) begin
            cycles++;
            @(negedge wire_clk_wz);
        end
        if (o_debug_state !== 4'(debug_pkg::ST_IDLE))
            abort_run("Timeout while waiting for the debug unit to return to idle");
    endtask

    task automatic check_outputs();
        check_equal(32'(o_pc), 32'(model_pc), "o_pc");
        check_equal(o_instr, model_instr, "o_instr");
        check_equal(o_cycle_count, model_count, "o_cycle_count");
        check_equal(32'(o_halt), 32'(model_instr === debug_pkg::HALT_WORD), "o_halt");
        check_equal(32'(o_debug_state), 32'(debug_pkg::ST_IDLE), "o_debug_state");
    endtask

    task automatic load_words(input int count);
        int k;
        int b;
        send_byte(debug_pkg::CMD_LOAD);
        send_byte(uart_pkg::byte_t'(count));
        for (k = 0; k < count; k++)
            for (b = 0; b < 4; b++)
                send_byte(model_mem[k][8*b +: 8]);  // least significant byte first
        wait_idle();
    endtask

    task automatic step_and_check();
        model_step();
        send_byte(debug_pkg::CMD_STEP);
        wait_pc(model_pc);
        check_outputs();
    endtask

    task automatic clear_and_check();
        model_pc    = '0;
        model_instr = '0;
        model_count = '0;
        send_byte(debug_pkg::CMD_CLEAR);
        wait_pc('0);
        check_outputs();
    endtask

    task automatic run_and_check();
        int guard;
        guard = 0;
        while (model_instr !== debug_pkg::HALT_WORD && guard < debug_pkg::MEM_DEPTH) begin
            model_step();
            guard++;
        end
        send_byte(debug_pkg::CMD_RUN);
        wait_pc(model_pc);
        wait_idle();
        check_outputs();
    endtask

    initial begin
        int k;
        debug_pkg::word_t w;
        i_reset     = 1'b1;
        i_uart_rx   = 1'b1;                     // serial line idles high
        seed        = 32'h2928;
        model_pc    = '0;
        model_instr = '0;
        model_count = '0;
        repeat (4) @(posedge wire_clk_wz);
        i_reset <= 1'b0;
        @(negedge wire_clk_wz);
        check_outputs();

        // first program, the fifth word halts
        for (k = 0; k < 4; k++)
            model_mem[k] = random_word();
        model_mem[4] = debug_pkg::HALT_WORD;
        load_words(5);
        step_and_check();
        step_and_check();

        // unknown command and a frame with a low stop bit
        send_byte(8'h3F);
        wait_idle();
        check_outputs();
        send_frame(debug_pkg::CMD_STEP, 1'b0);
        wait_idle();
        check_outputs();
        repeat (3) step_and_check();

        // second program written over the first
        clear_and_check();
        for (k = 0; k < 3; k++) begin
            w = random_word();
            model_mem[k] = (w == model_mem[k]) ? w + 1 : w;
        end
        model_mem[3] = debug_pkg::HALT_WORD;
        load_words(4);
        step_and_check();
        step_and_check();

        clear_and_check();
        run_and_check();
        check_equal(32'(o_pc), 32'd4, "o_pc after run");
        check_equal(o_cycle_count, 32'd4, "o_cycle_count after run");
        check_equal(32'(o_halt), 32'd1, "o_halt after run");
        step_and_check();                       // ignored while halted

        if (i_dut.u_checker.failures == 0)
            $display("TEST RESULT: PASS");
        else
            abort_run("A concurrent assertion in the bound checker failed");
        $finish;
    end

endmodule

// File: filelist.f
rtl/uart_pkg.sv
rtl/debug_pkg.sv
rtl/uart_rx.sv
rtl/debug_unit.sv
rtl/instr_mem.sv
rtl/fetch_unit.sv
rtl/debug_top.sv
dv/debug_checker.sv
dv/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f filelist.f -o sim_tb

status=0
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a pass"
    exit 1
fi
echo "simulation passed"
